//--- verilog/term_pkg.sv
// Widths, terminal codes and memory port codes shared by the host terminals
// Memory commands always carry a burst length of zero, one 32-bit word
package term_pkg;

   typedef logic [15:0] term_addr_t;
   typedef logic [31:0] reg_addr_t;
   typedef logic [15:0] reg_data_t;
   typedef logic [31:0] mem_word_t;
   typedef logic [29:0] mem_addr_t;
   typedef logic [5:0]  burst_len_t;

   // Memory port instruction field
   typedef enum logic [2:0] {
      mem_write = 3'd0,
      mem_read  = 3'd1
   } mem_instr_t;

   // Terminal codes seen on term_addr
   localparam term_addr_t TERM_DRAM      = 16'h0010;
   localparam term_addr_t TERM_DRAM_CTRL = 16'h0011;
   localparam term_addr_t TERM_DUMMY     = 16'h0012;

   // Fixed answer of the dummy terminal
   localparam reg_data_t DUMMY_VALUE = 16'h9988;

   // DRAM control terminal register map
   localparam reg_addr_t CTRL_REG_STATUS    = 32'd0;
   localparam reg_addr_t CTRL_REG_SCRATCH   = 32'd1;
   localparam reg_addr_t CTRL_REG_CMD_COUNT = 32'd2;

endpackage

//--- verilog/term_router.sv
// Purely combinational decode of term_addr; strobes reach one terminal only
// Unmapped codes read zero and never hold off the host
`timescale 1ns/1ns

module term_router (
   input  term_pkg::term_addr_t term_addr,
   input  logic                 read_mode,
   input  logic                 read_req,
   input  logic                 read,
   input  logic                 write_mode,
   input  logic                 write,
   input  term_pkg::reg_data_t  dram_datao,
   input  term_pkg::reg_data_t  ctrl_datao,
   input  logic                 dram_read_rdy,
   input  logic                 dram_write_rdy,
   output logic                 dram_read_mode,
   output logic                 dram_read_req,
   output logic                 dram_read,
   output logic                 dram_write_mode,
   output logic                 dram_write,
   output logic                 ctrl_write,
   output term_pkg::reg_data_t  reg_datao,
   output logic                 read_rdy,
   output logic                 write_rdy,
   output term_pkg::reg_data_t  transfer_status
);
   import term_pkg::*;

   logic sel_dram;
   logic sel_ctrl;

   assign sel_dram = (term_addr == TERM_DRAM);
   assign sel_ctrl = (term_addr == TERM_DRAM_CTRL);

   assign dram_read_mode  = sel_dram & read_mode;
   assign dram_read_req   = sel_dram & read_req;
   assign dram_read       = sel_dram & read;
   assign dram_write_mode = sel_dram & write_mode;
   assign dram_write      = sel_dram & write;
   // Control registers only care about the write pulse
   assign ctrl_write      = sel_ctrl & write_mode & write;

   // No terminal reports a transfer error
   assign transfer_status = '0;

   // Return path
   always_comb begin
      reg_datao = '0;
      read_rdy  = 1'b1;
      write_rdy = 1'b1;
      case (term_addr)
         TERM_DRAM: begin
            reg_datao = dram_datao;
            read_rdy  = dram_read_rdy;
            write_rdy = dram_write_rdy;
         end
         TERM_DRAM_CTRL: reg_datao = ctrl_datao;
         TERM_DUMMY:     reg_datao = DUMMY_VALUE;
         default:        reg_datao = '0;
      endcase
   end

endmodule

//--- verilog/dram_bridge.sv
// Packs host halfword pairs, low half first, into single-word memory commands
// A transfer starting at an odd halfword address continues a parked half word
`timescale 1ns/1ns

module dram_bridge (
   input  logic                 ifclk,
   input  logic                 rst,
   input  logic                 read_mode,
   input  logic                 read_req,
   input  logic                 read,
   input  logic                 write_mode,
   input  logic                 write,
   input  term_pkg::reg_addr_t  reg_addr,
   input  term_pkg::reg_data_t  reg_datai,
   input  logic                 cmd_full,
   input  logic                 rd_empty,
   input  term_pkg::mem_word_t  rd_data,
   input  logic                 calib_done,
   output term_pkg::reg_data_t  reg_datao,
   output logic                 read_rdy,
   output logic                 write_rdy,
   output logic                 cmd_en,
   output term_pkg::mem_instr_t cmd_instr,
   output term_pkg::burst_len_t cmd_bl,
   output term_pkg::mem_addr_t  cmd_byte_addr,
   output logic                 wr_en,
   output term_pkg::mem_word_t  wr_data,
   output logic                 rd_en
);
   import term_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_wr_low,
      st_wr_issue,
      st_rd_issue,
      st_rd_wait,
      st_rd_high
   } state_t;

   state_t    state;
   state_t    state_cur;
   logic      write_mode_q;
   logic      read_mode_q;
   logic      wr_start;
   logic      rd_start;
   logic      resume;
   logic      high_req;
   logic      addr_step;
   logic      rdy_set;
   logic      rdy_q;
   logic      half_q;
   mem_addr_t addr_q;
   mem_addr_t addr_base;
   mem_word_t wr_word;
   mem_word_t rd_word;

   assign wr_start = write_mode & ~write_mode_q;
   assign rd_start = read_mode & ~read_mode_q;
   assign resume   = reg_addr[1] &
                     ((wr_start & (state == st_wr_low)) | (rd_start & (state == st_rd_high)));

   // Any other new transfer drops a parked half word
   always_comb begin
      state_cur = state;
      if ((wr_start || rd_start) && !resume &&
          (state == st_wr_low || state == st_rd_high))
         state_cur = st_idle;
   end

   assign high_req  = (state_cur == st_rd_high) & read_mode & read_req;
   // Word address moves on once a word is issued or fully read
   assign addr_step = (state_cur == st_wr_issue) | high_req;
   assign addr_base = (wr_start || rd_start) ? {reg_addr[29:2], 2'b00} : addr_q;
   assign rdy_set   = rd_en | high_req;

   assign cmd_en        = (state == st_wr_issue) | ((state == st_rd_issue) & ~cmd_full);
   assign cmd_instr     = (state == st_rd_issue) ? mem_read : mem_write;
   assign cmd_bl        = '0;
   assign cmd_byte_addr = addr_q;
   assign wr_en         = (state == st_wr_issue);
   assign wr_data       = wr_word;
   assign rd_en         = (state == st_rd_wait) & ~rd_empty;

   assign write_rdy = calib_done & ~cmd_full & ((state == st_idle) | (state == st_wr_low));
   assign read_rdy  = rdy_q;
   assign reg_datao = half_q ? rd_word[31:16] : rd_word[15:0];

   always_ff @(posedge ifclk) begin
      if (rst) begin
         state        <= st_idle;
         write_mode_q <= 1'b0;
         read_mode_q  <= 1'b0;
         rdy_q        <= 1'b0;
      end else begin
         write_mode_q <= write_mode;
         read_mode_q  <= read_mode;
         if (!read_mode)
            rdy_q <= 1'b0;
         else if (rdy_set)
            rdy_q <= 1'b1;
         else if (read)
            rdy_q <= 1'b0;
         state <= state_cur;
         case (state_cur)
            st_idle: begin
               if (write)
                  state <= st_wr_low;
               else if (read_mode && read_req)
                  state <= st_rd_issue;
            end
            st_wr_low: begin
               if (write)
                  state <= st_wr_issue;
            end
            st_wr_issue: state <= st_idle;
            st_rd_issue: begin
               if (!cmd_full)
                  state <= st_rd_wait;
            end
            st_rd_wait: begin
               if (!rd_empty)
                  state <= st_rd_high;
            end
            st_rd_high: begin
               if (high_req)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge ifclk) begin
      addr_q <= addr_base + (addr_step ? mem_addr_t'(4) : mem_addr_t'(0));
      if (state_cur == st_idle && write)
         wr_word[15:0] <= reg_datai;
      if (state_cur == st_wr_low && write)
         wr_word[31:16] <= reg_datai;
      if (rd_en)
         rd_word <= rd_data;
      if (rdy_set)
         half_q <= high_req;
   end

   // Write issue is unconditional; write_rdy must have left the port free
   a_cmd_not_full: assert property (@(posedge ifclk) disable iff (rst)
      cmd_en |-> !cmd_full);

endmodule

//--- verilog/mem_port_model.sv
// Single-port memory controller model; one-word bursts, no write masks
// MEM_WORDS and QUEUE_DEPTH must be powers of two, QUEUE_DEPTH at least 2
`timescale 1ns/1ns

module mem_port_model #(
   parameter int MEM_WORDS    = 64,
   parameter int CALIB_CYCLES = 16,
   parameter int QUEUE_DEPTH  = 4
) (
   input  logic                 ifclk,
   input  logic                 rst,
   input  logic                 cmd_en,
   input  term_pkg::mem_instr_t cmd_instr,
   input  term_pkg::burst_len_t cmd_bl,
   input  term_pkg::mem_addr_t  cmd_byte_addr,
   input  logic                 wr_en,
   input  term_pkg::mem_word_t  wr_data,
   input  logic                 rd_en,
   output logic                 cmd_full,
   output term_pkg::mem_word_t  rd_data,
   output logic                 rd_empty,
   output logic                 calib_done
);
   import term_pkg::*;

   localparam int WORD_AW = $clog2(MEM_WORDS);
   localparam int PTR_W   = $clog2(QUEUE_DEPTH);
   localparam int CAL_W   = $clog2(CALIB_CYCLES + 1);
   // Queue slots
   localparam int WQ = 0;
   localparam int RQ = 1;

   logic [CAL_W-1:0]   calib_cnt;
   logic               cmd_valid;
   mem_instr_t         cmd_instr_q;
   mem_addr_t          cmd_addr_q;
   logic [WORD_AW-1:0] word_idx;
   logic               exec_write;
   logic               exec_read;
   mem_word_t          ram [MEM_WORDS];

   mem_word_t          q_mem [2][QUEUE_DEPTH];
   logic [PTR_W-1:0]   q_wptr [2];
   logic [PTR_W-1:0]   q_rptr [2];
   logic [PTR_W:0]     q_count [2];
   logic [1:0]         q_push;
   logic [1:0]         q_pop;
   mem_word_t          q_din [2];

   always_ff @(posedge ifclk) begin
      if (rst) begin
         calib_cnt  <= '0;
         calib_done <= 1'b0;
      end else if (!calib_done) begin
         if (calib_cnt == CAL_W'(CALIB_CYCLES - 1))
            calib_done <= 1'b1;
         calib_cnt <= calib_cnt + 1'b1;
      end
   end

   // One command in flight, executed the cycle after it is accepted
   always_ff @(posedge ifclk) begin
      if (rst)
         cmd_valid <= 1'b0;
      else
         cmd_valid <= cmd_en;
   end

   always_ff @(posedge ifclk) begin
      if (cmd_en) begin
         cmd_instr_q <= cmd_instr;
         cmd_addr_q  <= cmd_byte_addr;
      end
   end

   assign cmd_full   = ~calib_done | cmd_valid;
   // Byte address over 4, wrapped to the RAM size
   assign word_idx   = cmd_addr_q[WORD_AW+1:2];
   assign exec_write = cmd_valid & (cmd_instr_q == mem_write);
   assign exec_read  = cmd_valid & (cmd_instr_q == mem_read);

   assign q_push[WQ] = wr_en;
   assign q_din[WQ]  = wr_data;
   assign q_pop[WQ]  = exec_write;
   assign q_push[RQ] = exec_read;
   assign q_din[RQ]  = ram[word_idx];
   assign q_pop[RQ]  = rd_en;

   always_ff @(posedge ifclk) begin
      for (int i = 0; i < 2; i++) begin
         if (rst) begin
            q_wptr[i]  <= '0;
            q_rptr[i]  <= '0;
            q_count[i] <= '0;
         end else begin
            if (q_push[i])
               q_wptr[i] <= q_wptr[i] + 1'b1;
            if (q_pop[i])
               q_rptr[i] <= q_rptr[i] + 1'b1;
            if (q_push[i] && !q_pop[i])
               q_count[i] <= q_count[i] + 1'b1;
            else if (q_pop[i] && !q_push[i])
               q_count[i] <= q_count[i] - 1'b1;
         end
      end
   end

   always_ff @(posedge ifclk) begin
      for (int i = 0; i < 2; i++) begin
         if (q_push[i])
            q_mem[i][q_wptr[i]] <= q_din[i];
      end
      if (exec_write)
         ram[word_idx] <= q_mem[WQ][q_rptr[WQ]];
   end

   assign rd_data  = q_mem[RQ][q_rptr[RQ]];
   assign rd_empty = (q_count[RQ] == '0);

   a_cmd_after_calib: assert property (@(posedge ifclk) disable iff (rst)
      cmd_en |-> calib_done);

   // Write data has to be queued no later than its command
   a_wr_data_ready: assert property (@(posedge ifclk) disable iff (rst)
      exec_write |-> q_count[WQ] != '0);

   // The read queue is never popped while empty
   a_rd_not_empty: assert property (@(posedge ifclk) disable iff (rst)
      rd_en |-> !rd_empty);

   a_single_word: assert property (@(posedge ifclk) disable iff (rst)
      cmd_en |-> cmd_bl == '0);

endmodule

//--- verilog/dram_ctrl_term.sv
// DRAM control terminal: status, scratch and memory command counter
// Registers read back combinationally; other addresses read zero
`timescale 1ns/1ns

module dram_ctrl_term (
   input  logic                ifclk,
   input  logic                rst,
   input  logic                write,
   input  term_pkg::reg_addr_t reg_addr,
   input  term_pkg::reg_data_t reg_datai,
   input  logic                calib_done,
   input  logic                cmd_en,
   output term_pkg::reg_data_t reg_datao
);
   import term_pkg::*;

   reg_data_t scratch;
   reg_data_t cmd_count;

   always_ff @(posedge ifclk) begin
      if (rst) begin
         scratch   <= '0;
         cmd_count <= '0;
      end else begin
         if (write && reg_addr == CTRL_REG_SCRATCH)
            scratch <= reg_datai;
         // Any write clears the counter, the data is ignored
         if (write && reg_addr == CTRL_REG_CMD_COUNT)
            cmd_count <= '0;
         else if (cmd_en)
            cmd_count <= cmd_count + 1'b1;
      end
   end

   always_comb begin
      case (reg_addr)
         CTRL_REG_STATUS:    reg_datao = {15'd0, calib_done};
         CTRL_REG_SCRATCH:   reg_datao = scratch;
         CTRL_REG_CMD_COUNT: reg_datao = cmd_count;
         default:            reg_datao = '0;
      endcase
   end

endmodule

//--- verilog/host_terminal_top.sv
// Host register bus routed to the DRAM data, DRAM control and dummy terminals
// MEM_WORDS and QUEUE_DEPTH must be powers of two
`timescale 1ns/1ns

module host_terminal_top #(
   parameter int MEM_WORDS    = 64,
   parameter int CALIB_CYCLES = 16,
   parameter int QUEUE_DEPTH  = 4
) (
   input  logic                 ifclk,
   input  logic                 rst,
   input  term_pkg::term_addr_t term_addr,
   input  term_pkg::reg_addr_t  reg_addr,
   input  logic [31:0]          len,
   input  logic                 read_mode,
   input  logic                 read_req,
   input  logic                 read,
   input  logic                 write_mode,
   input  logic                 write,
   input  term_pkg::reg_data_t  reg_datai,
   output term_pkg::reg_data_t  reg_datao,
   output logic                 read_rdy,
   output logic                 write_rdy,
   output term_pkg::reg_data_t  transfer_status
);
   import term_pkg::*;

   logic       dram_read_mode;
   logic       dram_read_req;
   logic       dram_read;
   logic       dram_write_mode;
   logic       dram_write;
   logic       ctrl_write;
   reg_data_t  dram_datao;
   reg_data_t  ctrl_datao;
   logic       dram_read_rdy;
   logic       dram_write_rdy;
   logic       cmd_en;
   mem_instr_t cmd_instr;
   burst_len_t cmd_bl;
   mem_addr_t  cmd_byte_addr;
   logic       wr_en;
   mem_word_t  wr_data;
   logic       rd_en;
   logic       cmd_full;
   mem_word_t  rd_data;
   logic       rd_empty;
   logic       calib_done;

   term_router term_router_i (
      .term_addr       (term_addr),
      .read_mode       (read_mode),
      .read_req        (read_req),
      .read            (read),
      .write_mode      (write_mode),
      .write           (write),
      .dram_datao      (dram_datao),
      .ctrl_datao      (ctrl_datao),
      .dram_read_rdy   (dram_read_rdy),
      .dram_write_rdy  (dram_write_rdy),
      .dram_read_mode  (dram_read_mode),
      .dram_read_req   (dram_read_req),
      .dram_read       (dram_read),
      .dram_write_mode (dram_write_mode),
      .dram_write      (dram_write),
      .ctrl_write      (ctrl_write),
      .reg_datao       (reg_datao),
      .read_rdy        (read_rdy),
      .write_rdy       (write_rdy),
      .transfer_status (transfer_status)
   );

   dram_bridge dram_bridge_i (
      .ifclk         (ifclk),
      .rst           (rst),
      .read_mode     (dram_read_mode),
      .read_req      (dram_read_req),
      .read          (dram_read),
      .write_mode    (dram_write_mode),
      .write         (dram_write),
      .reg_addr      (reg_addr),
      .reg_datai     (reg_datai),
      .cmd_full      (cmd_full),
      .rd_empty      (rd_empty),
      .rd_data       (rd_data),
      .calib_done    (calib_done),
      .reg_datao     (dram_datao),
      .read_rdy      (dram_read_rdy),
      .write_rdy     (dram_write_rdy),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .rd_en         (rd_en)
   );

   dram_ctrl_term dram_ctrl_term_i (
      .ifclk      (ifclk),
      .rst        (rst),
      .write      (ctrl_write),
      .reg_addr   (reg_addr),
      .reg_datai  (reg_datai),
      .calib_done (calib_done),
      .cmd_en     (cmd_en),
      .reg_datao  (ctrl_datao)
   );

   mem_port_model #(
      .MEM_WORDS    (MEM_WORDS),
      .CALIB_CYCLES (CALIB_CYCLES),
      .QUEUE_DEPTH  (QUEUE_DEPTH)
   ) mem_port_model_i (
      .ifclk         (ifclk),
      .rst           (rst),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .cmd_full      (cmd_full),
      .rd_data       (rd_data),
      .rd_empty      (rd_empty),
      .calib_done    (calib_done)
   );

   // The host holds len for the whole transfer
   a_len_stable: assert property (@(posedge ifclk) disable iff (rst)
      (read_mode || write_mode) && $past(read_mode || write_mode) |-> $stable(len));

endmodule

//--- bench/host_terminal_tb.sv
// Table-driven testbench for host_terminal_top with default parameters
// One halfword per row; DRAM rows rely on the bridge resuming at odd halfwords
`timescale 1ns/1ns

module host_terminal_tb;
   import term_pkg::*;

   localparam int CYCLE_NS  = 40;
   localparam int NUM_ROWS  = 36;
   localparam int MEM_WORDS = 64;
   localparam term_addr_t TERM_UNMAPPED = 16'h0020;

   typedef enum {op_write, op_read, op_poll} op_t;

   logic       ifclk;
   logic       rst;
   term_addr_t term_addr;
   reg_addr_t  reg_addr;
   logic [31:0] len;
   logic       read_mode;
   logic       read_req;
   logic       read;
   logic       write_mode;
   logic       write;
   reg_data_t  reg_datai;
   reg_data_t  reg_datao;
   logic       read_rdy;
   logic       write_rdy;
   reg_data_t  transfer_status;

   // Stimulus table
   op_t        row_op   [NUM_ROWS];
   term_addr_t row_term [NUM_ROWS];
   reg_addr_t  row_addr [NUM_ROWS];
   reg_data_t  row_data [NUM_ROWS];
   reg_data_t  row_exp  [NUM_ROWS];
   int         row_count;

   integer     seed;
   int         errors;
   int         checks;
   int         row_errors;
   int         waits;
   reg_data_t  rd_val;
   string      op_name;

   host_terminal_top host_terminal_top_i (
      .ifclk           (ifclk),
      .rst             (rst),
      .term_addr       (term_addr),
      .reg_addr        (reg_addr),
      .len             (len),
      .read_mode       (read_mode),
      .read_req        (read_req),
      .read            (read),
      .write_mode      (write_mode),
      .write           (write),
      .reg_datai       (reg_datai),
      .reg_datao       (reg_datao),
      .read_rdy        (read_rdy),
      .write_rdy       (write_rdy),
      .transfer_status (transfer_status)
   );

   always #(CYCLE_NS / 2) ifclk = ~ifclk;

   task automatic add_row(input op_t op, input term_addr_t t, input reg_addr_t a,
                          input reg_data_t d, input reg_data_t e);
      row_op[row_count]   = op;
      row_term[row_count] = t;
      row_addr[row_count] = a;
      row_data[row_count] = d;
      row_exp[row_count]  = e;
      row_count++;
   endtask

   task automatic build_table();
      reg_data_t burst [8];
      reg_data_t wrap [4];
      reg_data_t scratch_val;
      row_count = 0;
      add_row(op_read, TERM_DUMMY, 32'h0000_0000, 16'h0, DUMMY_VALUE);
      add_row(op_read, TERM_DUMMY, 32'h0000_1234, 16'h0, DUMMY_VALUE);
      add_row(op_read, TERM_UNMAPPED, 32'h0000_0005, 16'h0, 16'h0000);
      add_row(op_write, TERM_UNMAPPED, 32'h0000_0005, 16'h1111, 16'h0000);
      // Status bit 0 comes up with calibration
      add_row(op_poll, TERM_DRAM_CTRL, CTRL_REG_STATUS, 16'h0, 16'h0001);
      scratch_val = reg_data_t'($random(seed));
      add_row(op_write, TERM_DRAM_CTRL, CTRL_REG_SCRATCH, scratch_val, 16'h0);
      add_row(op_read, TERM_DRAM_CTRL, CTRL_REG_SCRATCH, 16'h0, scratch_val);
      add_row(op_write, TERM_DRAM_CTRL, CTRL_REG_CMD_COUNT, 16'hffff, 16'h0);
      for (int i = 0; i < 8; i++) begin
         burst[i] = reg_data_t'($random(seed));
         add_row(op_write, TERM_DRAM, 32'h40 + 2 * i, burst[i], 16'h0);
      end
      for (int i = 0; i < 8; i++)
         add_row(op_read, TERM_DRAM, 32'h40 + 2 * i, 16'h0, burst[i]);
      // 4 write and 4 read commands of one word each
      add_row(op_read, TERM_DRAM_CTRL, CTRL_REG_CMD_COUNT, 16'h0, 16'd8);
      // One RAM size above 0x40 lands on the same words
      for (int i = 0; i < 4; i++) begin
         wrap[i] = reg_data_t'($random(seed));
         add_row(op_write, TERM_DRAM, 32'h40 + MEM_WORDS * 4 + 2 * i, wrap[i], 16'h0);
      end
      for (int i = 0; i < 4; i++)
         add_row(op_read, TERM_DRAM, 32'h40 + 2 * i, 16'h0, wrap[i]);
      // Two more word writes and two word reads, then a clear of a nonzero count
      add_row(op_read, TERM_DRAM_CTRL, CTRL_REG_CMD_COUNT, 16'h0, 16'd12);
      add_row(op_write, TERM_DRAM_CTRL, CTRL_REG_CMD_COUNT, 16'h5a5a, 16'h0);
      add_row(op_read, TERM_DRAM_CTRL, CTRL_REG_CMD_COUNT, 16'h0, 16'd0);
   endtask

   // Called and returns on a falling edge with the mode low again
   task automatic write_halfword(input term_addr_t t, input reg_addr_t a,
                                 input reg_data_t d, output int n_wait);
      n_wait     = 0;
      term_addr  = t;
      reg_addr   = a;
      write_mode = 1'b1;
      @(negedge ifclk);
      while (!write_rdy) begin
         n_wait++;
         @(negedge ifclk);
      end
      reg_datai = d;
      write     = 1'b1;
      @(negedge ifclk);
      write      = 1'b0;
      write_mode = 1'b0;
      @(negedge ifclk);
   endtask

   task automatic read_halfword(input term_addr_t t, input reg_addr_t a,
                                output reg_data_t d, output int n_wait);
      n_wait    = 0;
      term_addr = t;
      reg_addr  = a;
      read_mode = 1'b1;
      @(negedge ifclk);
      read_req = 1'b1;
      @(negedge ifclk);
      read_req = 1'b0;
      while (!read_rdy) begin
         n_wait++;
         @(negedge ifclk);
      end
      d    = reg_datao;
      read = 1'b1;
      @(negedge ifclk);
      read      = 1'b0;
      read_mode = 1'b0;
      @(negedge ifclk);
   endtask

   initial begin
      #(CYCLE_NS * 200 * NUM_ROWS);
      $display("Timeout: the DUT stopped answering the host bus");
      $display("Test failed");
      $finish;
   end

   initial begin
      ifclk      = 1'b0;
      rst        = 1'b1;
      term_addr  = '0;
      reg_addr   = '0;
      len        = 32'd2;
      read_mode  = 1'b0;
      read_req   = 1'b0;
      read       = 1'b0;
      write_mode = 1'b0;
      write      = 1'b0;
      reg_datai  = '0;
      errors     = 0;
      checks     = 0;
      seed       = 32'hd9bc_6b19;
      build_table();
      repeat (3) @(posedge ifclk);
      @(negedge ifclk);
      rst = 1'b0;

      for (int r = 0; r < row_count; r++) begin
         row_errors = errors;
         rd_val     = '0;
         case (row_op[r])
            op_write: begin
               op_name = "write";
               write_halfword(row_term[r], row_addr[r], row_data[r], waits);
            end
            op_read: begin
               op_name = "read";
               read_halfword(row_term[r], row_addr[r], rd_val, waits);
               checks++;
               if (rd_val !== row_exp[r]) begin
                  $display("FAIL t=%0t reg_datao expected %h got %h",
                           $time, row_exp[r], rd_val);
                  errors++;
               end
            end
            default: begin
               op_name = "poll";
               read_halfword(row_term[r], row_addr[r], rd_val, waits);
               while (rd_val !== row_exp[r])
                  read_halfword(row_term[r], row_addr[r], rd_val, waits);
            end
         endcase
         // Only the DRAM terminal may hold the host off
         checks++;
         if (row_term[r] != TERM_DRAM && waits != 0) begin
            $display("Row %0d: terminal %h made the host wait %0d cycles",
                     r, row_term[r], waits);
            errors++;
         end
         checks++;
         if (transfer_status !== '0) begin
            $display("FAIL t=%0t transfer_status expected %h got %h",
                     $time, 16'h0000, transfer_status);
            errors++;
         end
         $display("row %0d %s term %h addr %h data %h: %0d errors",
                  r, op_name, row_term[r], row_addr[r],
                  (row_op[r] == op_write) ? row_data[r] : rd_val, errors - row_errors);
      end

      $display("rows %0d, checks %0d, errors %0d", row_count, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- build.f
verilog/term_pkg.sv
verilog/term_router.sv
verilog/dram_bridge.sv
verilog/mem_port_model.sv
verilog/dram_ctrl_term.sv
verilog/host_terminal_top.sv
bench/host_terminal_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the host terminal testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module host_terminal_tb -f build.f -o sim_host_terminal
if [ $? -ne 0 ]; then
   echo "Verilator compile step returned an error"
   exit 1
fi

./obj_dir/sim_host_terminal > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0
